// ==== dcache_pkg.sv ====
// ==============================
// dcache shared definitions
// widths, opcodes and the structs on the core and memory sides
// ==============================
package dcache_pkg;

  parameter int ADDR_W     = 32;
  parameter int WORD_W     = 32;
  parameter int LINE_WORDS = 4;
  parameter int OFS_W      = 4;
  parameter int IDX_W_DEF  = 4;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } mem_op_e;

  // size plus extension for loads
  typedef enum logic [2:0] {
    SZ_B,
    SZ_H,
    SZ_W,
    SZ_BU,
    SZ_HU
  } size_e;

  typedef struct packed {
    logic              valid;
    mem_op_e           op;
    size_e             size;
    logic [ADDR_W-1:0] addr;
    word_t             wdata;
  } cpu_req_t;

  typedef struct packed {
    logic  valid;
    logic  ale;
    word_t rdata;
  } cpu_rsp_t;

  // cache to memory request without the write data
  typedef struct packed {
    logic              rd_valid;
    logic              wr_valid;
    logic              wlast;
    logic [ADDR_W-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic  rd_ready;
    logic  wr_ready;
    logic  rvalid;
    logic  rlast;
    word_t rdata;
  } mem_rsp_t;

endpackage

// ==== dcache_align.sv ====
// ==============================
// dcache alignment unit
// align check, load extract and extend, store byte merge
// ==============================
`timescale 1ns/100ps

module dcache_align (
  input  dcache_pkg::cpu_req_t req_i,
  input  dcache_pkg::line_t    line_i,
  output logic                 ale_o,
  output dcache_pkg::word_t    load_word_o,
  output dcache_pkg::line_t    merged_line_o
);
  import dcache_pkg::*;

  word_t                       word;
  logic [7:0]                  byte_v;
  logic [15:0]                 half_v;
  logic [OFS_W-1:0]            ofs;
  logic [LINE_WORDS*4-1:0][7:0] lanes;

  assign ofs = req_i.addr[OFS_W-1:0];

  // halfword needs bit 0 clear, word needs both low bits clear
  always_comb begin
    case (req_i.size)
      SZ_H, SZ_HU: ale_o = req_i.addr[0];
      SZ_W:        ale_o = |req_i.addr[1:0];
      default:     ale_o = 1'b0;
    endcase
  end

  // ==============================
  // load path
  // ==============================
  assign word   = line_i[ofs[OFS_W-1:2]];
  assign byte_v = word[ofs[1:0]*8 +: 8];
  assign half_v = word[ofs[1]*16 +: 16];

  always_comb begin
    case (req_i.size)
      SZ_B:    load_word_o = {{24{byte_v[7]}}, byte_v};
      SZ_H:    load_word_o = {{16{half_v[15]}}, half_v};
      SZ_BU:   load_word_o = {24'b0, byte_v};
      SZ_HU:   load_word_o = {16'b0, half_v};
      default: load_word_o = word;
    endcase
  end

  // ==============================
  // store merge
  // ==============================
  always_comb begin
    lanes = line_i;
    case (req_i.size)
      SZ_B, SZ_BU: begin
        lanes[ofs] = req_i.wdata[7:0];
      end
      SZ_H, SZ_HU: begin
        lanes[ofs]        = req_i.wdata[7:0];
        lanes[ofs + 4'd1] = req_i.wdata[15:8];
      end
      default: begin
        lanes[ofs]        = req_i.wdata[7:0];
        lanes[ofs + 4'd1] = req_i.wdata[15:8];
        lanes[ofs + 4'd2] = req_i.wdata[23:16];
        lanes[ofs + 4'd3] = req_i.wdata[31:24];
      end
    endcase
    merged_line_o = lanes;
  end

endmodule

// ==== dcache_array.sv ====
// ==============================
// dcache storage, two ways
// tag, valid, dirty, lru and data with hit compare and victim pick
// ==============================
`timescale 1ns/100ps

module dcache_array #(
  parameter int IDX_W = dcache_pkg::IDX_W_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [IDX_W-1:0]  rd_idx_i,
  input  logic [dcache_pkg::ADDR_W-IDX_W-dcache_pkg::OFS_W-1:0] tag_i,
  output logic              hit_o,
  output logic              hit_way_o,
  output dcache_pkg::line_t hit_line_o,
  output logic              victim_way_o,
  output logic              victim_dirty_o,
  output logic [dcache_pkg::ADDR_W-IDX_W-dcache_pkg::OFS_W-1:0] victim_tag_o,
  output dcache_pkg::line_t victim_line_o,
  input  logic              line_we_i,
  input  logic              we_way_i,
  input  dcache_pkg::line_t wline_i,
  input  logic              set_dirty_i,
  input  logic              lru_touch_i
);
  import dcache_pkg::*;

  localparam int TAG_W = ADDR_W - IDX_W - OFS_W;
  localparam int SETS  = 1 << IDX_W;

  line_t            data_mem [2][SETS];
  logic [TAG_W-1:0] tag_mem  [2][SETS];
  logic [SETS-1:0][1:0] valid_q;
  logic [SETS-1:0][1:0] dirty_q;
  logic [SETS-1:0]      lru_q;

  // registered read port
  line_t            line_rd [2];
  logic [TAG_W-1:0] tag_rd  [2];
  logic [1:0]       valid_rd;
  logic [1:0]       dirty_rd;
  logic             lru_rd;
  logic [1:0]       way_hit;

  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      line_rd[w] <= data_mem[w][rd_idx_i];
      tag_rd[w]  <= tag_mem[w][rd_idx_i];
    end
    if (line_we_i) begin
      data_mem[we_way_i][rd_idx_i] <= wline_i;
      tag_mem[we_way_i][rd_idx_i]  <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q  <= '0;
      dirty_q  <= '0;
      lru_q    <= '0;
      valid_rd <= '0;
      dirty_rd <= '0;
      lru_rd   <= 1'b0;
    end else begin
      valid_rd <= valid_q[rd_idx_i];
      dirty_rd <= dirty_q[rd_idx_i];
      lru_rd   <= lru_q[rd_idx_i];
      if (line_we_i) begin
        valid_q[rd_idx_i][we_way_i] <= 1'b1;
        dirty_q[rd_idx_i][we_way_i] <= set_dirty_i;
      end
      // point at the way not just used
      if (lru_touch_i) begin
        lru_q[rd_idx_i] <= ~hit_way_o;
      end
    end
  end

  // ==============================
  // hit and victim
  // ==============================
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid_rd[w] && (tag_rd[w] == tag_i);
    end
  end

  assign hit_o      = |way_hit;
  assign hit_way_o  = way_hit[1];
  assign hit_line_o = line_rd[hit_way_o];

  // empty way first, else lru
  assign victim_way_o   = !valid_rd[0] ? 1'b0 : (!valid_rd[1] ? 1'b1 : lru_rd);
  assign victim_dirty_o = valid_rd[victim_way_o] && dirty_rd[victim_way_o];
  assign victim_tag_o   = tag_rd[victim_way_o];
  assign victim_line_o  = line_rd[victim_way_o];

endmodule

// ==== dcache_ctrl.sv ====
// ==============================
// dcache controller
// request register, miss FSM, write-back and refill bursts
// ==============================
`timescale 1ns/100ps

module dcache_ctrl #(
  parameter int IDX_W = dcache_pkg::IDX_W_DEF
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  output logic                 ready_o,
  output dcache_pkg::cpu_rsp_t cpu_rsp_o,
  output dcache_pkg::mem_req_t mem_req_o,
  output dcache_pkg::word_t    mem_wdata_o,
  input  dcache_pkg::mem_rsp_t mem_rsp_i,
  output logic [IDX_W-1:0]     rd_idx_o,
  input  logic                 hit_i,
  input  logic                 hit_way_i,
  input  logic                 victim_way_i,
  input  logic                 victim_dirty_i,
  input  logic [dcache_pkg::ADDR_W-IDX_W-dcache_pkg::OFS_W-1:0] victim_tag_i,
  input  dcache_pkg::line_t    victim_line_i,
  output dcache_pkg::cpu_req_t req_o,
  input  logic                 ale_i,
  input  dcache_pkg::word_t    load_word_i,
  input  dcache_pkg::line_t    merged_line_i,
  output logic                 line_we_o,
  output logic                 we_way_o,
  output dcache_pkg::line_t    wline_o,
  output logic                 set_dirty_o,
  output logic                 lru_touch_o
);
  import dcache_pkg::*;

  localparam int TAG_W = ADDR_W - IDX_W - OFS_W;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL_REQ,
    REFILL,
    REPLAY
  } cache_state_e;

  cache_state_e state_q, state_d;
  cpu_req_t     req_q;
  logic [1:0]   beat_q;
  line_t        buf_q;
  line_t        refill_line;
  logic [IDX_W-1:0] req_idx;
  logic [TAG_W-1:0] req_tag;
  logic         lookup_ok;
  logic         store_hit;
  logic         last_rd_beat;

  assign req_idx      = req_q.addr[OFS_W +: IDX_W];
  assign req_tag      = req_q.addr[ADDR_W-1 -: TAG_W];
  assign lookup_ok    = (state_q == LOOKUP) && (hit_i || ale_i);
  assign store_hit    = (state_q == LOOKUP) && hit_i && !ale_i && (req_q.op == OP_STORE);
  assign last_rd_beat = (state_q == REFILL) && mem_rsp_i.rvalid && mem_rsp_i.rlast;

  // ==============================
  // next state
  // ==============================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cpu_req_i.valid) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit_i || ale_i) begin
          state_d = IDLE;
        end else if (victim_dirty_i) begin
          state_d = WRITEBACK;
        end else begin
          state_d = REFILL_REQ;
        end
      end
      WRITEBACK: begin
        if (mem_rsp_i.wr_ready && beat_q == 2'd3) begin
          state_d = REFILL_REQ;
        end
      end
      REFILL_REQ: begin
        if (mem_rsp_i.rd_ready) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (last_rd_beat) begin
          state_d = REPLAY;
        end
      end
      REPLAY: state_d = LOOKUP;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == WRITEBACK && mem_rsp_i.wr_ready) begin
        beat_q <= beat_q + 2'd1;
      end else if (last_rd_beat) begin
        beat_q <= '0;
      end else if (state_q == REFILL && mem_rsp_i.rvalid) begin
        beat_q <= beat_q + 2'd1;
      end
    end
  end

  // request and refill buffer
  always_ff @(posedge clk) begin
    if (state_q == IDLE && cpu_req_i.valid) begin
      req_q <= cpu_req_i;
    end
    if (state_q == REFILL && mem_rsp_i.rvalid) begin
      buf_q[beat_q] <= mem_rsp_i.rdata;
    end
  end

  // last beat goes straight into the line being written
  always_comb begin
    refill_line         = buf_q;
    refill_line[beat_q] = mem_rsp_i.rdata;
  end

  // ==============================
  // array and core side
  // ==============================
  assign rd_idx_o    = (state_q == IDLE) ? cpu_req_i.addr[OFS_W +: IDX_W] : req_idx;
  assign req_o       = req_q;
  assign line_we_o   = store_hit || last_rd_beat;
  assign we_way_o    = (state_q == REFILL) ? victim_way_i : hit_way_i;
  assign wline_o     = (state_q == REFILL) ? refill_line : merged_line_i;
  assign set_dirty_o = store_hit;
  assign lru_touch_o = (state_q == LOOKUP) && hit_i && !ale_i;

  assign ready_o         = (state_q == IDLE);
  assign cpu_rsp_o.valid = lookup_ok;
  assign cpu_rsp_o.ale   = ale_i;
  assign cpu_rsp_o.rdata = load_word_i;

  // bus side with line aligned addresses
  assign mem_req_o.rd_valid = (state_q == REFILL_REQ);
  assign mem_req_o.wr_valid = (state_q == WRITEBACK);
  assign mem_req_o.wlast    = (state_q == WRITEBACK) && (beat_q == 2'd3);
  assign mem_req_o.addr     = (state_q == WRITEBACK) ?
                              {victim_tag_i, req_idx, {OFS_W{1'b0}}} :
                              {req_tag, req_idx, {OFS_W{1'b0}}};
  assign mem_wdata_o        = victim_line_i[beat_q];

endmodule

// ==== dcache_top.sv ====
// ==============================
// dcache top level
// two-way write-back data cache with burst memory bus
// ==============================
`timescale 1ns/100ps

module dcache_top #(
  parameter int IDX_W = dcache_pkg::IDX_W_DEF
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  output logic                 ready_o,
  output dcache_pkg::cpu_rsp_t cpu_rsp_o,
  output dcache_pkg::mem_req_t mem_req_o,
  output dcache_pkg::word_t    mem_wdata_o,
  input  dcache_pkg::mem_rsp_t mem_rsp_i
);
  import dcache_pkg::*;

  localparam int TAG_W = ADDR_W - IDX_W - OFS_W;

  logic [IDX_W-1:0] rd_idx;
  logic             hit;
  logic             hit_way;
  line_t            hit_line;
  logic             victim_way;
  logic             victim_dirty;
  logic [TAG_W-1:0] victim_tag;
  line_t            victim_line;
  cpu_req_t         req;
  logic             ale;
  word_t            load_word;
  line_t            merged_line;
  logic             line_we;
  logic             we_way;
  line_t            wline;
  logic             set_dirty;
  logic             lru_touch;

  dcache_ctrl #(
    .IDX_W (IDX_W)
  ) u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_req_i      (cpu_req_i),
    .ready_o        (ready_o),
    .cpu_rsp_o      (cpu_rsp_o),
    .mem_req_o      (mem_req_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_rsp_i      (mem_rsp_i),
    .rd_idx_o       (rd_idx),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .victim_dirty_i (victim_dirty),
    .victim_tag_i   (victim_tag),
    .victim_line_i  (victim_line),
    .req_o          (req),
    .ale_i          (ale),
    .load_word_i    (load_word),
    .merged_line_i  (merged_line),
    .line_we_o      (line_we),
    .we_way_o       (we_way),
    .wline_o        (wline),
    .set_dirty_o    (set_dirty),
    .lru_touch_o    (lru_touch)
  );

  // tag compare uses the registered request
  dcache_array #(
    .IDX_W (IDX_W)
  ) u_array (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_idx_i       (rd_idx),
    .tag_i          (req.addr[ADDR_W-1 -: TAG_W]),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .hit_line_o     (hit_line),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),
    .victim_line_o  (victim_line),
    .line_we_i      (line_we),
    .we_way_i       (we_way),
    .wline_i        (wline),
    .set_dirty_i    (set_dirty),
    .lru_touch_i    (lru_touch)
  );

  dcache_align u_align (
    .req_i         (req),
    .line_i        (hit_line),
    .ale_o         (ale),
    .load_word_o   (load_word),
    .merged_line_o (merged_line)
  );

endmodule

// ==== tb_clk_gen.sv ====
// ==============================
// testbench clock and reset
// ==============================
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 5,
  parameter int RST_CYCLES  = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== tb_checker.sv ====
// ==============================
// dcache response and burst checker
// reference memory, load compare, write burst shape
// ==============================
`timescale 1ns/100ps

module tb_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  input  logic                 ready_i,
  input  dcache_pkg::cpu_rsp_t cpu_rsp_i,
  input  dcache_pkg::mem_req_t mem_req_i,
  input  dcache_pkg::word_t    mem_wdata_i,
  input  dcache_pkg::mem_rsp_t mem_rsp_i,
  output int                   errors_o,
  output int                   wr_beats_o
);
  import dcache_pkg::*;

  word_t       ref_mem [logic [31:0]];
  cpu_req_t    pend;
  logic        pend_v = 1'b0;
  logic [1:0]  wbeat = 2'd0;
  logic [31:0] wbase = '0;
  int          err_cnt = 0;
  int          beat_cnt = 0;

  assign errors_o   = err_cnt;
  assign wr_beats_o = beat_cnt;

  // initial memory content that depends on every address bit
  function automatic word_t pattern_word(logic [31:0] a);
    return (a * 32'h9e3779b1) ^ 32'h5bd1e995;
  endfunction

  function automatic word_t ref_read(logic [31:0] a);
    logic [31:0] key;
    key = {a[31:2], 2'b00};
    if (ref_mem.exists(key)) begin
      return ref_mem[key];
    end
    return pattern_word(key);
  endfunction

  function automatic logic exp_ale(cpu_req_t r);
    case (r.size)
      SZ_H, SZ_HU: return r.addr[0];
      SZ_W:        return |r.addr[1:0];
      default:     return 1'b0;
    endcase
  endfunction

  function automatic word_t exp_load(cpu_req_t r);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    w = ref_read(r.addr);
    b = w[8*r.addr[1:0] +: 8];
    h = w[16*r.addr[1] +: 16];
    case (r.size)
      SZ_B:    return {{24{b[7]}}, b};
      SZ_BU:   return {24'h0, b};
      SZ_H:    return {{16{h[15]}}, h};
      SZ_HU:   return {16'h0, h};
      default: return w;
    endcase
  endfunction

  task automatic store_ref(cpu_req_t r);
    word_t w;
    w = ref_read(r.addr);
    case (r.size)
      SZ_B, SZ_BU: w[8*r.addr[1:0] +: 8] = r.wdata[7:0];
      SZ_H, SZ_HU: w[16*r.addr[1] +: 16] = r.wdata[15:0];
      default:     w = r.wdata;
    endcase
    ref_mem[{r.addr[31:2], 2'b00}] = w;
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      // ready only while no request is outstanding
      if (ready_i !== !pend_v) begin
        $display("MISMATCH ready_o expected %h got %h", !pend_v, ready_i);
        err_cnt++;
      end
      // response for the pending request
      if (cpu_rsp_i.valid) begin
        if (!pend_v) begin
          $display("response arrived with no request outstanding");
          err_cnt++;
        end else begin
          if (cpu_rsp_i.ale !== exp_ale(pend)) begin
            $display("MISMATCH cpu_rsp_o.ale addr %h expected %h got %h",
                     pend.addr, exp_ale(pend), cpu_rsp_i.ale);
            err_cnt++;
          end else if (pend.op == OP_LOAD && !cpu_rsp_i.ale &&
                       cpu_rsp_i.rdata !== exp_load(pend)) begin
            $display("MISMATCH cpu_rsp_o.rdata addr %h expected %h got %h",
                     pend.addr, exp_load(pend), cpu_rsp_i.rdata);
            err_cnt++;
          end
        end
        pend_v = 1'b0;
      end
      if (cpu_req_i.valid && ready_i) begin
        pend   = cpu_req_i;
        pend_v = 1'b1;
        if (cpu_req_i.op == OP_STORE && !exp_ale(cpu_req_i)) begin
          store_ref(cpu_req_i);
        end
      end
      // ==============================
      // write burst shape and data
      // ==============================
      if (mem_req_i.wr_valid && mem_rsp_i.wr_ready) begin
        if (wbeat == 2'd0) begin
          wbase = mem_req_i.addr;
          if (mem_req_i.addr[3:0] != 4'h0) begin
            $display("write burst starts at address %h, not line aligned", mem_req_i.addr);
            err_cnt++;
          end
        end else if (mem_req_i.addr !== wbase) begin
          $display("MISMATCH mem_req_o.addr expected %h got %h", wbase, mem_req_i.addr);
          err_cnt++;
        end
        if (mem_req_i.wlast !== (wbeat == 2'd3)) begin
          $display("MISMATCH mem_req_o.wlast beat %h expected %h got %h",
                   wbeat, (wbeat == 2'd3), mem_req_i.wlast);
          err_cnt++;
        end
        if (mem_wdata_i !== ref_read(wbase + {wbeat, 2'b00})) begin
          $display("MISMATCH mem_wdata_o addr %h expected %h got %h",
                   wbase + {wbeat, 2'b00}, ref_read(wbase + {wbeat, 2'b00}), mem_wdata_i);
          err_cnt++;
        end
        wbeat = wbeat + 2'd1;
        beat_cnt++;
      end
    end
  end

endmodule

// ==== tb_dcache_sva.sv ====
// ==============================
// dcache port assertions
// ==============================
`timescale 1ns/100ps

module tb_dcache_sva (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 ready_o,
  input dcache_pkg::cpu_rsp_t cpu_rsp_o,
  input dcache_pkg::mem_req_t mem_req_o,
  input dcache_pkg::mem_rsp_t mem_rsp_i
);

  a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_rsp_o.valid |=> !cpu_rsp_o.valid)
    else $error("response valid high on two consecutive cycles");

  a_bus_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_req_o.rd_valid && mem_req_o.wr_valid))
    else $error("read and write requests high together");

  // write address held until accepted
  a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o.wr_valid && !mem_rsp_i.wr_ready |=>
      mem_req_o.wr_valid && $stable(mem_req_o.addr))
    else $error("write request dropped or address changed before wr_ready");

  a_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> ready_o && !mem_req_o.rd_valid && !mem_req_o.wr_valid)
    else $error("outputs not idle in the first cycle after reset");

endmodule

// ==== tb_dcache.sv ====
// ==============================
// dcache testbench top
// stimulus table, burst memory model, timeout
// ==============================
`timescale 1ns/100ps

module tb_dcache;
  import dcache_pkg::*;

  typedef struct packed {
    mem_op_e     op;
    size_e       size;
    logic [31:0] addr;
    word_t       wdata;
    logic        exp_hit;
  } entry_t;

  logic     clk;
  logic     rst_n;
  cpu_req_t cpu_req;
  logic     ready;
  cpu_rsp_t cpu_rsp;
  mem_req_t mem_req;
  word_t    mem_wdata;
  mem_rsp_t mem_rsp = '0;
  int       chk_errors;
  int       chk_wr_beats;

  entry_t      table_q [$];
  int          tb_errors = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 1000;
  logic [31:0] rng_state = 32'd29574;
  word_t       mem [logic [31:0]];
  int          wait_cnt;
  logic [1:0]  wbeat;
  logic [1:0]  rbeat;
  logic        rbusy;
  logic [31:0] rbase;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dcache_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cpu_req_i   (cpu_req),
    .ready_o     (ready),
    .cpu_rsp_o   (cpu_rsp),
    .mem_req_o   (mem_req),
    .mem_wdata_o (mem_wdata),
    .mem_rsp_i   (mem_rsp)
  );

  tb_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .cpu_req_i   (cpu_req),
    .ready_i     (ready),
    .cpu_rsp_i   (cpu_rsp),
    .mem_req_i   (mem_req),
    .mem_wdata_i (mem_wdata),
    .mem_rsp_i   (mem_rsp),
    .errors_o    (chk_errors),
    .wr_beats_o  (chk_wr_beats)
  );

  bind dcache_top tb_dcache_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .ready_o   (ready_o),
    .cpu_rsp_o (cpu_rsp_o),
    .mem_req_o (mem_req_o),
    .mem_rsp_i (mem_rsp_i)
  );

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t pattern_word(logic [31:0] a);
    return (a * 32'h9e3779b1) ^ 32'h5bd1e995;
  endfunction

  function automatic word_t mem_read(logic [31:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return pattern_word(a);
  endfunction

  function automatic int next_delay();
    rng_state = xorshift(rng_state);
    return int'(rng_state % 3);
  endfunction

  task automatic add(mem_op_e op, size_e size, logic [31:0] addr, word_t wdata, logic hit);
    table_q.push_back('{op: op, size: size, addr: addr, wdata: wdata, exp_hit: hit});
  endtask

  // ==============================
  // memory model
  // ==============================
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rsp  <= '0;
      wait_cnt <= 0;
      wbeat    <= 2'd0;
      rbeat    <= 2'd0;
      rbusy    <= 1'b0;
      rbase    <= '0;
    end else if (mem_req.wr_valid && mem_rsp.wr_ready) begin
      mem[mem_req.addr + {wbeat, 2'b00}] = mem_wdata;
      wbeat            <= wbeat + 2'd1;
      mem_rsp.wr_ready <= 1'b0;
      wait_cnt         <= next_delay();
    end else if (mem_req.rd_valid && mem_rsp.rd_ready) begin
      // first beat goes out right after the handshake
      mem_rsp.rd_ready <= 1'b0;
      mem_rsp.rvalid   <= 1'b1;
      mem_rsp.rlast    <= 1'b0;
      mem_rsp.rdata    <= mem_read(mem_req.addr);
      rbase            <= mem_req.addr;
      rbeat            <= 2'd0;
      rbusy            <= 1'b1;
      wait_cnt         <= next_delay();
    end else if (mem_req.wr_valid || mem_req.rd_valid) begin
      if (wait_cnt == 0) begin
        mem_rsp.wr_ready <= mem_req.wr_valid;
        mem_rsp.rd_ready <= mem_req.rd_valid;
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end else if (rbusy) begin
      if (rbeat == 2'd3) begin
        mem_rsp.rvalid <= 1'b0;
        mem_rsp.rlast  <= 1'b0;
        rbusy          <= 1'b0;
      end else begin
        rbeat         <= rbeat + 2'd1;
        mem_rsp.rdata <= mem_read(rbase + {rbeat + 2'd1, 2'b00});
        mem_rsp.rlast <= (rbeat == 2'd2);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, DUT stopped responding", cycle_cnt);
      $display("tests failed");
      $finish;
    end
  end

  // send one request and wait for its response
  task automatic run_entry(int i);
    int lat;
    @(posedge clk);
    while (!ready) @(posedge clk);
    cpu_req.valid <= 1'b1;
    cpu_req.op    <= table_q[i].op;
    cpu_req.size  <= table_q[i].size;
    cpu_req.addr  <= table_q[i].addr;
    cpu_req.wdata <= table_q[i].wdata;
    @(posedge clk);
    cpu_req.valid <= 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!cpu_rsp.valid);
    if (table_q[i].exp_hit && lat != 1) begin
      $display("entry %0d at %h expected to hit but answered after %0d cycles",
               i, table_q[i].addr, lat);
      tb_errors++;
    end else if (!table_q[i].exp_hit && lat == 1) begin
      $display("entry %0d at %h expected to miss but answered after one cycle",
               i, table_q[i].addr);
      tb_errors++;
    end
  endtask

  task automatic run_range(int lo, int hi, int exp_beats);
    int beats0;
    beats0 = chk_wr_beats;
    for (int i = lo; i <= hi; i++) begin
      run_entry(i);
    end
    if (exp_beats >= 0 && chk_wr_beats - beats0 != exp_beats) begin
      $display("entries %0d to %0d gave %0d write beats instead of %0d",
               lo, hi, chk_wr_beats - beats0, exp_beats);
      tb_errors++;
    end
  endtask

  initial begin
    cpu_req = '0;
    // fresh lines in every size
    add(OP_LOAD,  SZ_W,  32'h1000, 32'h0, 1'b0);
    add(OP_LOAD,  SZ_B,  32'h1001, 32'h0, 1'b1);
    add(OP_LOAD,  SZ_BU, 32'h1003, 32'h0, 1'b1);
    add(OP_LOAD,  SZ_H,  32'h1002, 32'h0, 1'b1);
    add(OP_LOAD,  SZ_HU, 32'h100e, 32'h0, 1'b1);
    add(OP_LOAD,  SZ_W,  32'h100c, 32'h0, 1'b1);
    add(OP_LOAD,  SZ_B,  32'h2015, 32'h0, 1'b0);
    add(OP_LOAD,  SZ_HU, 32'h2016, 32'h0, 1'b1);
    // store then load back
    add(OP_STORE, SZ_B,  32'h1005, 32'h0000_0080, 1'b1);
    add(OP_STORE, SZ_H,  32'h100a, 32'h0000_beef, 1'b1);
    add(OP_STORE, SZ_W,  32'h1000, 32'h1234_5678, 1'b1);
    add(OP_LOAD,  SZ_B,  32'h1005, 32'h0, 1'b1);
    add(OP_LOAD,  SZ_HU, 32'h100a, 32'h0, 1'b1);
    add(OP_LOAD,  SZ_H,  32'h100a, 32'h0, 1'b1);
    add(OP_LOAD,  SZ_W,  32'h1000, 32'h0, 1'b1);
    // set 0 conflicts with two dirty evictions
    add(OP_STORE, SZ_W,  32'h1104, 32'hcafe_0001, 1'b0);
    add(OP_LOAD,  SZ_W,  32'h1200, 32'h0, 1'b0);
    add(OP_LOAD,  SZ_W,  32'h1000, 32'h0, 1'b0);
    add(OP_LOAD,  SZ_W,  32'h1104, 32'h0, 1'b0);
    add(OP_LOAD,  SZ_H,  32'h100a, 32'h0, 1'b1);
    add(OP_LOAD,  SZ_B,  32'h1005, 32'h0, 1'b1);
    // loads only through set 5
    add(OP_LOAD,  SZ_W,  32'h3050, 32'h0, 1'b0);
    add(OP_LOAD,  SZ_W,  32'h3150, 32'h0, 1'b0);
    add(OP_LOAD,  SZ_W,  32'h3250, 32'h0, 1'b0);
    add(OP_LOAD,  SZ_BU, 32'h3057, 32'h0, 1'b0);
    add(OP_LOAD,  SZ_W,  32'h3350, 32'h0, 1'b0);
    add(OP_LOAD,  SZ_H,  32'h3152, 32'h0, 1'b0);
    add(OP_LOAD,  SZ_HU, 32'h3256, 32'h0, 1'b0);
    // misaligned
    add(OP_LOAD,  SZ_H,  32'h1001, 32'h0, 1'b1);
    add(OP_LOAD,  SZ_W,  32'h1002, 32'h0, 1'b1);
    add(OP_STORE, SZ_W,  32'h1006, 32'hdead_beef, 1'b1);
    add(OP_STORE, SZ_H,  32'h1003, 32'h0000_7777, 1'b1);
    add(OP_LOAD,  SZ_W,  32'h1004, 32'h0, 1'b1);
    add(OP_LOAD,  SZ_HU, 32'h2013, 32'h0, 1'b1);
    cycle_limit = table_q.size() * 40 + 20;

    wait (rst_n === 1'b1);
    run_range(0, 14, 0);
    run_range(15, 20, 8);
    run_range(21, 27, 0);
    run_range(28, table_q.size() - 1, -1);

    repeat (2) @(posedge clk);
    $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
dcache_pkg.sv
dcache_align.sv
dcache_array.sv
dcache_ctrl.sv
dcache_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_dcache_sva.sv
tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_dcache -Mdir obj_dir -o tb_dcache_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0
